/* hdl/fp16_pkg.sv */
package fp16_pkg;

    // ieee half precision field layout
    localparam int fp16_w = 16;
    localparam int exp_w  = 5;
    localparam int man_w  = 10;
    // significand with the hidden bit in front
    localparam int sig_w  = 11;

    // exponent encoding limits
    localparam int exp_bias = 15;
    // largest finite biased exponent
    localparam int exp_max  = 30;
    // all ones exponent, written on overflow
    localparam int exp_inf  = 31;

    // sign action carried from stage 1 to stage 2
    localparam logic [1:0] sgn_keep  = 2'd0;
    localparam logic [1:0] sgn_flip  = 2'd1;
    localparam logic [1:0] sgn_clear = 2'd2;

    // operations the pipeline can apply
    typedef enum logic [1:0] {
        // a * b
        op_mul     = 2'd0,
        // -(a * b)
        op_mul_neg = 2'd1,
        // |a * b|
        op_mul_abs = 2'd2,
        // a * a, b is ignored
        op_square  = 2'd3
    } fp16_op_e;

endpackage

/* hdl/wallacetree_11b.sv */
`timescale 1ns/1ps

module wallacetree_11b import fp16_pkg::*; (
    input  logic [sig_w-1:0] a,
    input  logic [sig_w-1:0] b,
    output logic [12:0]      result,
    output logic             overflow,
    output logic             round_loss
);

    localparam int prod_w = 2 * sig_w;

    // one shifted partial product per bit of b
    logic [prod_w-1:0] pp [sig_w];

    // running carry-save pair
    logic [prod_w-1:0] sum_v;
    logic [prod_w-1:0] carry_v;

    // outputs of the current compressor row
    logic [prod_w-1:0] row_s;
    logic [prod_w-1:0] row_c;

    // full 22 bit product after the final add
    logic [prod_w-1:0] prod;

    // partial products, a gated by each bit of b
    always_comb begin
        for (int i = 0; i < sig_w; i++) begin
            if (b[i]) begin
                pp[i] = {{sig_w{1'b0}}, a} << i;
            end else begin
                pp[i] = '0;
            end
        end
    end

    // 3:2 reduction, one row per remaining partial product
    always_comb begin
        // first two rows start the redundant pair
        sum_v   = pp[0];
        carry_v = pp[1];
        row_s   = '0;
        row_c   = '0;
        for (int i = 2; i < sig_w; i++) begin
            // full adder per column, half adder where a column only has two bits
            row_s   = sum_v ^ carry_v ^ pp[i];
            row_c   = ((sum_v & carry_v) | (sum_v & pp[i]) | (carry_v & pp[i])) << 1;
            sum_v   = row_s;
            carry_v = row_c;
        end
    end

    // carry propagate add collapses the pair
    // product fits in 22 bits, so the dropped carry out of row_c is always zero
    assign prod = sum_v + carry_v;

    // bit 21 set means the significand product is in [2,4)
    assign overflow = prod[prod_w-1];

    // top 13 bits below the carry position
    // field slices in the multiplier pick mantissa, guard and low bit from here
    assign result = prod[prod_w-2:8];

    // everything under the window collapses into a sticky bit
    assign round_loss = |prod[8:0];

endmodule

/* hdl/adder_5b.sv */
`timescale 1ns/1ps

module adder_5b import fp16_pkg::*; (
    input  logic             carry,
    input  logic [exp_w-1:0] exp1,
    input  logic [exp_w-1:0] exp2,
    output logic [exp_w-1:0] sum,
    output logic             ovf,
    output logic             unf
);

    // raw sum of both biased exponents plus mantissa carry, max 63
    logic [6:0] raw_sum;
    // raw sum minus one bias, two's complement at 7 bits
    logic [6:0] biased;

    assign raw_sum = {2'b00, exp1} + {2'b00, exp2} + {6'd0, carry};
    assign biased  = raw_sum - 7'(exp_bias);

    // negative or zero result exponent cannot be encoded as normal
    assign unf = biased[6] | (biased == 7'd0);

    // positive but past the largest finite exponent
    assign ovf = ~biased[6] & (biased[5:0] > 6'(exp_max));

    // saturate on either limit, else take the low five bits
    always_comb begin
        if (ovf) begin
            sum = exp_w'(exp_inf);
        end else if (unf) begin
            sum = '0;
        end else begin
            sum = biased[exp_w-1:0];
        end
    end

endmodule

/* hdl/mul_fp16_nolatch.sv */
`timescale 1ns/1ps

module mul_fp16_nolatch import fp16_pkg::*; (
    input  logic [fp16_w-1:0] a,
    input  logic [fp16_w-1:0] b,
    output logic [fp16_w-1:0] result,
    output logic              ovf,
    output logic              unf
);

    // hidden bits, zero for a zero exponent field
    // subnormals are not renormalised
    logic hid_a;
    logic hid_b;
    logic [sig_w-1:0] sig_a;
    logic [sig_w-1:0] sig_b;

    assign hid_a = |a[fp16_w-2 -: exp_w];
    assign hid_b = |b[fp16_w-2 -: exp_w];
    assign sig_a = {hid_a, a[man_w-1:0]};
    assign sig_b = {hid_b, b[man_w-1:0]};

    // significand product through the carry-save tree
    logic [12:0] mul_product;
    logic        mul_carry;
    logic        mul_sticky;

    wallacetree_11b u_tree (
        .a          (sig_a),
        .b          (sig_b),
        .result     (mul_product),
        .overflow   (mul_carry),
        .round_loss (mul_sticky)
    );

    // result sign is just the xor of the input signs
    logic sign_res;
    assign sign_res = a[fp16_w-1] ^ b[fp16_w-1];

    // exponent sum, mantissa carry folded in
    logic [exp_w-1:0] exp_sum;
    logic             add_ovf;
    logic             add_unf;

    adder_5b u_exp_add (
        .carry (mul_carry),
        .exp1  (a[fp16_w-2 -: exp_w]),
        .exp2  (b[fp16_w-2 -: exp_w]),
        .sum   (exp_sum),
        .ovf   (add_ovf),
        .unf   (add_unf)
    );

    // normalise: drop one place when the product reached [2,4)
    // bits [11:2] mantissa, [1] guard, [0] the bit below guard
    logic [11:0] frac;
    assign frac = mul_carry ? mul_product[12:1] : mul_product[11:0];

    // round to nearest even
    logic round_up;
    assign round_up = frac[1] & (frac[0] | mul_sticky | frac[2]);

    // extra top bit catches the all ones mantissa rolling over
    logic [man_w:0] sig_rnd;
    assign sig_rnd = {1'b0, frac[11:2]} + {{man_w{1'b0}}, round_up};

    // true zero product, either significand is zero
    logic prod_zero;
    assign prod_zero = (sig_a == '0) | (sig_b == '0);

    // final exponent, bumped by a rounding carry unless already saturated
    logic [exp_w-1:0] exp_fin;
    always_comb begin
        if (prod_zero) begin
            exp_fin = '0;
        end else if (sig_rnd[man_w] & ~add_ovf & ~add_unf) begin
            exp_fin = exp_sum + 5'd1;
        end else begin
            exp_fin = exp_sum;
        end
    end

    assign result = {sign_res, exp_fin, sig_rnd[man_w-1:0]};

    // limit flags mean nothing for a zero product
    assign ovf = add_ovf & ~prod_zero;
    assign unf = add_unf & ~prod_zero;

endmodule

/* hdl/fp16_mul_pipe.sv */
`timescale 1ns/1ps

module fp16_mul_pipe import fp16_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  fp16_op_e          op,
    input  logic [fp16_w-1:0] a,
    input  logic [fp16_w-1:0] b,
    output logic              out_valid,
    output logic [fp16_w-1:0] result,
    output logic              out_ovf,
    output logic              out_unf
);

    // stage 1 holding registers
    logic              s1_valid;
    logic [fp16_w-1:0] s1_a;
    logic [fp16_w-1:0] s1_b;
    logic [1:0]        s1_sgn;

    // sign action decoded from the opcode at issue
    logic [1:0] sgn_act;
    always_comb begin
        case (op)
            op_mul_neg: sgn_act = sgn_flip;
            op_mul_abs: sgn_act = sgn_clear;
            default:    sgn_act = sgn_keep;
        endcase
    end

    // valid bit of stage 1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    // operands latched only on an accepted input, square reuses a
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_a   <= a;
            s1_b   <= (op == op_square) ? a : b;
            s1_sgn <= sgn_act;
        end
    end

    // combinational multiply between the stages
    logic [fp16_w-1:0] mul_res;
    logic              mul_ovf;
    logic              mul_unf;

    mul_fp16_nolatch u_mul (
        .a      (s1_a),
        .b      (s1_b),
        .result (mul_res),
        .ovf    (mul_ovf),
        .unf    (mul_unf)
    );

    // sign rewrite on the product
    logic sign_out;
    always_comb begin
        case (s1_sgn)
            sgn_flip:  sign_out = ~mul_res[fp16_w-1];
            sgn_clear: sign_out = 1'b0;
            default:   sign_out = mul_res[fp16_w-1];
        endcase
    end

    // stage 2 valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s1_valid;
        end
    end

    // stage 2 payload
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            result  <= {sign_out, mul_res[fp16_w-2:0]};
            out_ovf <= mul_ovf;
            out_unf <= mul_unf;
        end
    end

endmodule

/* hdl/fp16_ctrl_regs.sv */
`timescale 1ns/1ps

module fp16_ctrl_regs import fp16_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cfg_we,
    input  fp16_op_e cfg_op,
    input  logic     flag_clr,
    input  logic     res_valid,
    input  logic     res_ovf,
    input  logic     res_unf,
    output fp16_op_e cur_op,
    output logic     ovf_flag,
    output logic     unf_flag
);

    // qualified set conditions from a completed result
    logic set_ovf;
    logic set_unf;

    assign set_ovf = res_valid & res_ovf;
    assign set_unf = res_valid & res_unf;

    // opcode steering the pipeline, seen by inputs on the next edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cur_op <= op_mul;
        end else if (cfg_we) begin
            cur_op <= cfg_op;
        end
    end

    // sticky status, a set beats a clear in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ovf_flag <= 1'b0;
            unf_flag <= 1'b0;
        end else begin
            if (set_ovf) begin
                ovf_flag <= 1'b1;
            end else if (flag_clr) begin
                ovf_flag <= 1'b0;
            end
            if (set_unf) begin
                unf_flag <= 1'b1;
            end else if (flag_clr) begin
                unf_flag <= 1'b0;
            end
        end
    end

endmodule

/* hdl/fp16_mul_top.sv */
`timescale 1ns/1ps

module fp16_mul_top import fp16_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cfg_we,
    input  fp16_op_e          cfg_op,
    input  logic              flag_clr,
    input  logic              in_valid,
    input  logic [fp16_w-1:0] a,
    input  logic [fp16_w-1:0] b,
    output logic              out_valid,
    output logic [fp16_w-1:0] result,
    output logic              out_ovf,
    output logic              out_unf,
    output logic              ovf_flag,
    output logic              unf_flag
);

    // opcode from the register block into the pipeline
    fp16_op_e cur_op;

    // register block, fed back from the pipeline output
    fp16_ctrl_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_op    (cfg_op),
        .flag_clr  (flag_clr),
        .res_valid (out_valid),
        .res_ovf   (out_ovf),
        .res_unf   (out_unf),
        .cur_op    (cur_op),
        .ovf_flag  (ovf_flag),
        .unf_flag  (unf_flag)
    );

    // two stage multiply datapath
    fp16_mul_pipe u_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .op        (cur_op),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result),
        .out_ovf   (out_ovf),
        .out_unf   (out_unf)
    );

endmodule

/* testbench/fp16_mul_properties.sv */
`timescale 1ns/1ps

module fp16_mul_properties (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic out_valid,
    input logic flag_clr,
    input logic ovf_flag,
    input logic unf_flag
);

    // nothing can come out in the first two edges after release
    assert property (@(posedge clk)
        (rst_n && (!$past(rst_n) || !$past(rst_n, 2))) |-> !out_valid)
        else $error("out_valid high right after reset release");

    // fixed latency of two with one result per accepted input
    // inputs seen while reset was low never enter the pipe
    assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rst_n) && $past(rst_n, 2)) |-> (out_valid == $past(in_valid, 2)))
        else $error("out_valid does not trail in_valid by two cycles");

    // sticky bits only drop after a clear strobe
    assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ovf_flag) |-> $past(flag_clr))
        else $error("ovf_flag fell without flag_clr");

    assert property (@(posedge clk) disable iff (!rst_n)
        $fell(unf_flag) |-> $past(flag_clr))
        else $error("unf_flag fell without flag_clr");

endmodule

bind fp16_mul_top fp16_mul_properties u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .flag_clr  (flag_clr),
    .ovf_flag  (ovf_flag),
    .unf_flag  (unf_flag)
);

/* testbench/tb_fp16_mul.sv */
`timescale 1ns/1ps

module tb_fp16_mul import fp16_pkg::*; ();

    localparam int num_vec      = 25;
    // ctl, a, b, result, flags
    localparam int vec_cols     = 5;
    localparam int clk_period   = 100;
    localparam int reset_cycles = 4;
    // issue, opcode writes, drains and clears all fit well inside four cycles each
    localparam int cycle_limit  = num_vec * 4 + 50;

    logic              clk;
    logic              rst_n;
    logic              cfg_we;
    fp16_op_e          cfg_op;
    logic              flag_clr;
    logic              in_valid;
    logic [fp16_w-1:0] a;
    logic [fp16_w-1:0] b;
    logic              out_valid;
    logic [fp16_w-1:0] result;
    logic              out_ovf;
    logic              out_unf;
    logic              ovf_flag;
    logic              unf_flag;

    // raw words straight from the vector file
    logic [15:0] vec_mem [num_vec*vec_cols];
    // results still in flight as {ovf, unf, result}
    logic [17:0] exp_q [$];
    // sticky flags expected since the last clear
    logic        pred_ovf;
    logic        pred_unf;
    // opcode the register block holds after the latest write
    fp16_op_e    op_model;
    int          cycle_cnt = 0;

    fp16_mul_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_op    (cfg_op),
        .flag_clr  (flag_clr),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result),
        .out_ovf   (out_ovf),
        .out_unf   (out_unf),
        .ovf_flag  (ovf_flag),
        .unf_flag  (unf_flag)
    );

    always #(clk_period / 2) clk = ~clk;

    // hard stop if the pipeline stalls or loses a result
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input string name, input logic [15:0] exp_val,
                         input logic [15:0] act_val);
        if (act_val !== exp_val) begin
            $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp_val, act_val);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // at each falling edge check flags and any result, then drop the strobes
    task automatic next_cycle();
        logic [17:0] ent;
        @(negedge clk);
        check("ovf_flag", 16'(pred_ovf), 16'(ovf_flag));
        check("unf_flag", 16'(pred_unf), 16'(unf_flag));
        if (out_valid && exp_q.size() == 0) begin
            $display("out_valid was high at %0t with no operation in flight", $time);
            $display("TEST FAIL");
            $fatal(1, "unexpected result");
        end else if (out_valid) begin
            ent = exp_q.pop_front();
            check("result", ent[15:0], result);
            check("out_ovf", 16'(ent[17]), 16'(out_ovf));
            check("out_unf", 16'(ent[16]), 16'(out_unf));
            // flag lands on the next edge, so the prediction moves now
            pred_ovf = pred_ovf | ent[17];
            pred_unf = pred_unf | ent[16];
        end
        in_valid = 1'b0;
        cfg_we   = 1'b0;
        flag_clr = 1'b0;
    endtask

    task automatic drain_pipe();
        while (exp_q.size() != 0) begin
            next_cycle();
        end
    endtask

    // needs an empty pipe since a set on the same edge would win
    task automatic pulse_flag_clr();
        next_cycle();
        flag_clr = 1'b1;
        pred_ovf = 1'b0;
        pred_unf = 1'b0;
    endtask

    task automatic run_vector(input int idx);
        int       base;
        int       nxt;
        fp16_op_e op_cur;
        fp16_op_e op_nxt;
        base   = idx * vec_cols;
        nxt    = base + vec_cols;
        op_cur = fp16_op_e'(vec_mem[base][1:0]);
        // ctl bit 4 asks for an empty pipe and clean flags first
        if (vec_mem[base][4]) begin
            drain_pipe();
            pulse_flag_clr();
        end
        // separate opcode write when no lookahead already did it
        if (op_cur != op_model) begin
            next_cycle();
            cfg_we   = 1'b1;
            cfg_op   = op_cur;
            op_model = op_cur;
        end
        next_cycle();
        in_valid = 1'b1;
        a        = vec_mem[base+1];
        b        = vec_mem[base+2];
        exp_q.push_back({vec_mem[base+4][1:0], vec_mem[base+3]});
        // the next opcode is written on this edge and only affects later inputs
        if (idx + 1 < num_vec) begin
            op_nxt = fp16_op_e'(vec_mem[nxt][1:0]);
            if (!vec_mem[nxt][4] && op_nxt != op_model) begin
                cfg_we   = 1'b1;
                cfg_op   = op_nxt;
                op_model = op_nxt;
            end
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        // valid and an opcode write held high through reset
        // neither may leave a trace once reset is released
        cfg_we   = 1'b1;
        cfg_op   = op_square;
        flag_clr = 1'b0;
        in_valid = 1'b1;
        a        = '0;
        b        = '0;
        pred_ovf = 1'b0;
        pred_unf = 1'b0;
        op_model = op_mul;
        // marker fill shows a short file
        for (int i = 0; i < num_vec * vec_cols; i++) begin
            vec_mem[i] = 16'hdead ^ 16'(i);
        end
        $readmemh("testbench/fp16_mul_vectors.txt", vec_mem);
        if (vec_mem[num_vec*vec_cols-1] == (16'hdead ^ 16'(num_vec * vec_cols - 1))) begin
            $display("vector file holds fewer than %0d operations", num_vec);
            $display("TEST FAIL");
            $fatal(1, "short vector file");
        end
        repeat (reset_cycles) @(negedge clk);
        rst_n    = 1'b1;
        in_valid = 1'b0;
        cfg_we   = 1'b0;
        cfg_op   = op_mul;
        for (int i = 0; i < num_vec; i++) begin
            run_vector(i);
        end
        // final flags and then a clear with nothing in flight
        drain_pipe();
        pulse_flag_clr();
        next_cycle();
        next_cycle();
        $display("TEST PASS");
        $finish;
    end

endmodule

/* testbench/fp16_mul_vectors.txt */
// ctl a b result flags, ctl = opcode in bits 1:0, bit 4 clears sticky flags first
// flags = ovf in bit 1, unf in bit 0
// plain multiplies, with and without mantissa carry
00 3C00 3C00 3C00 0
00 3E00 3E00 4080 0
00 4000 4200 4600 0
00 3D00 B800 B900 0
// rounding: tie to odd lsb, tie kept even, sticky tie, all ones carry
00 3C01 3E00 3E02 0
00 3C03 3E00 3E04 0
00 3C01 3E01 3E03 0
00 3DA8 3DA8 4000 0
// opcode transforms and back to back switches
01 3E00 4000 C200 0
01 B800 4000 3C00 0
02 C200 3E00 4480 0
03 4200 FFFF 4880 0
03 C000 3C00 4400 0
00 4000 4200 4600 0
03 3DA8 1234 4000 0
// zero and subnormal operands
00 0000 4200 0000 0
00 8000 3C00 8000 0
00 0200 7800 3E00 0
00 0200 0200 0100 1
// exponent limits and sticky flag clears
00 7800 3C00 7800 0
00 2000 2000 0400 0
00 7800 4000 7C00 2
10 7A00 7A00 7C80 2
00 9E00 0600 8080 1
12 FA00 7A00 7C80 2

/* fp16_mul.f */
hdl/fp16_pkg.sv
hdl/wallacetree_11b.sv
hdl/adder_5b.sv
hdl/mul_fp16_nolatch.sv
hdl/fp16_mul_pipe.sv
hdl/fp16_ctrl_regs.sv
hdl/fp16_mul_top.sv
testbench/fp16_mul_properties.sv
testbench/tb_fp16_mul.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fp16_mul
FILELIST  ?= fp16_mul.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "TEST PASS" $(LOG); then \
		echo "no pass message in $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
